/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 3;
    localparam int SETS           = 1 << INDEX_W;
    localparam int WORDS_PER_LINE = 4;
    localparam int MEM_LATENCY    = 2;   // Cycles from read strobe to data.
    localparam int MEM_WORDS      = 32768;
    localparam logic [15:0] MEM_INIT_KEY = 16'hA5C3;

    typedef logic [15:0]         addr_t;
    typedef logic [15:0]         word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef enum logic [3:0] {
        IDLE,
        COMP_RD,
        COMP_WR,
        WB_0,
        WB_1,
        WB_2,
        WB_3,
        FILL_0,
        FILL_1,
        FILL_2,
        FILL_3,
        FILL_4,
        FILL_5
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     enable,
    input  wire cache_pkg::index_t  index,
    input  wire cache_pkg::offset_t offset,
    input  wire cache_pkg::tag_t    tag,
    input  wire                     comp,
    input  wire                     write,
    input  wire cache_pkg::word_t   cache_wdata,
    input  wire                     valid_in,
    input  wire                     dirty_in,
    output logic                    hit,
    output logic                    valid,
    output logic                    dirty,
    output cache_pkg::tag_t         tag_out,
    output cache_pkg::word_t        data_out
);
    import cache_pkg::*;

    tag_t            tag_mem [SETS];
    word_t           data_mem [SETS][WORDS_PER_LINE];
    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;   // Only meaningful while the valid bit is set.
    logic [1:0]      word_sel;

    assign word_sel = offset[2:1];   // Offset bit 0 selects a byte and is ignored.

    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign tag_out  = tag_mem[index];
    assign data_out = data_mem[index][word_sel];
    assign hit      = valid_bits[index] && (tag_mem[index] == tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (enable && write && !comp) begin
            valid_bits[index] <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable && write) begin
            if (comp) begin
                if (hit) begin
                    data_mem[index][word_sel] <= cache_wdata;
                    dirty_bits[index]         <= 1'b1;   // A write hit makes the line dirty.
                end
            end else begin
                data_mem[index][word_sel] <= cache_wdata;
                tag_mem[index]            <= tag;
                dirty_bits[index]         <= dirty_in;
            end
        end
    end

endmodule

`default_nettype wire

/* design/way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module way_select (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   hit_0,
    input  wire                   hit_1,
    input  wire                   valid_0,
    input  wire                   valid_1,
    input  wire                   dirty_0,
    input  wire                   dirty_1,
    input  wire cache_pkg::tag_t  tag_0,
    input  wire cache_pkg::tag_t  tag_1,
    input  wire cache_pkg::word_t data_0,
    input  wire cache_pkg::word_t data_1,
    input  wire                   way_capture,
    input  wire                   fill_done,
    output logic                  enable_0,
    output logic                  enable_1,
    output logic                  hit,
    output logic                  evict_dirty,
    output cache_pkg::tag_t       line_tag,
    output cache_pkg::word_t      line_data
);

    logic sel_now;    // Way picked by the lookup in the current cycle.
    logic target_q;
    logic victim_q;
    logic sel;

    always_comb begin
        if (hit_0) begin
            sel_now = 1'b0;
        end else if (hit_1) begin
            sel_now = 1'b1;
        end else if (!valid_0) begin
            sel_now = 1'b0;
        end else if (!valid_1) begin
            sel_now = 1'b1;
        end else begin
            sel_now = victim_q;
        end
    end

    // In the compare cycle only a hit way may be written.
    assign enable_0 = way_capture ? hit_0 : !target_q;
    assign enable_1 = way_capture ? hit_1 : target_q;

    assign sel         = way_capture ? sel_now : target_q;
    assign hit         = hit_0 || hit_1;
    assign evict_dirty = sel ? (valid_1 && dirty_1) : (valid_0 && dirty_0);
    assign line_tag    = sel ? tag_1 : tag_0;
    assign line_data   = sel ? data_1 : data_0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target_q <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            if (way_capture) begin
                target_q <= sel_now;
            end
            if (fill_done) begin
                victim_q <= !victim_q;
            end
        end
    end

endmodule

`default_nettype wire

/* cache_ctrl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cache_pkg::addr_t addr,
    input  wire cache_pkg::word_t data_in,
    input  wire                   rd,
    input  wire                   wr,
    input  wire                   hit,
    input  wire                   evict_dirty,
    input  wire cache_pkg::tag_t  line_tag,
    input  wire cache_pkg::word_t line_data,
    input  wire cache_pkg::word_t mem_rdata,
    output cache_pkg::index_t     index,
    output cache_pkg::offset_t    offset,
    output cache_pkg::tag_t       tag,
    output logic                  comp,
    output logic                  write,
    output cache_pkg::word_t      cache_wdata,
    output logic                  valid_in,
    output logic                  dirty_in,
    output logic                  way_capture,
    output logic                  fill_done,
    output cache_pkg::addr_t      mem_addr,
    output logic                  mem_write,
    output logic                  mem_read,
    output cache_pkg::word_t      data_out,
    output logic                  done,
    output logic                  stall,
    output logic                  cache_hit
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t nxt_state;
    logic        req_wr;
    word_t       read_q;
    logic [1:0]  req_word;
    logic [1:0]  wb_word;
    logic [1:0]  rd_word;     // Line word whose memory read is issued now.
    logic [1:0]  fill_word;   // Line word arriving from memory now.
    logic        issue_rd;
    logic        fill_wr;

    assign req_word = addr[2:1];
    assign index    = addr[10:3];
    assign tag      = addr[15:11];

    always_comb begin
        wb_word   = 2'd0;
        rd_word   = 2'd0;
        fill_word = 2'd0;
        issue_rd  = 1'b0;
        fill_wr   = 1'b0;
        case (state)
            WB_1: wb_word = 2'd1;
            WB_2: wb_word = 2'd2;
            WB_3: wb_word = 2'd3;
            FILL_0: issue_rd = 1'b1;
            FILL_1: begin
                issue_rd = 1'b1;
                rd_word  = 2'd1;
            end
            FILL_2: begin
                issue_rd = 1'b1;
                rd_word  = 2'd2;
                fill_wr  = 1'b1;
            end
            FILL_3: begin
                issue_rd  = 1'b1;
                rd_word   = 2'd3;
                fill_wr   = 1'b1;
                fill_word = 2'd1;
            end
            FILL_4: begin
                fill_wr   = 1'b1;
                fill_word = 2'd2;
            end
            FILL_5: begin
                fill_wr   = 1'b1;
                fill_word = 2'd3;
            end
            default: begin
                wb_word = 2'd0;
            end
        endcase
    end

    always_comb begin
        nxt_state   = state;
        offset      = addr[2:0];
        comp        = 1'b0;
        write       = 1'b0;
        cache_wdata = data_in;
        valid_in    = 1'b0;
        dirty_in    = 1'b0;
        way_capture = 1'b0;
        fill_done   = 1'b0;
        mem_addr    = {addr[15:3], 3'b000};
        mem_write   = 1'b0;
        mem_read    = 1'b0;
        data_out    = read_q;
        done        = 1'b0;
        stall       = 1'b1;
        cache_hit   = 1'b0;

        if (issue_rd) begin
            mem_read = 1'b1;
            mem_addr = {addr[15:3], rd_word, 1'b0};
        end
        if (fill_wr) begin
            write    = 1'b1;
            offset   = {fill_word, 1'b0};
            valid_in = 1'b1;
            dirty_in = req_wr;
            // The requested word takes the processor data on a write miss.
            cache_wdata = (req_wr && fill_word == req_word) ? data_in : mem_rdata;
        end

        case (state)
            IDLE: begin
                stall = 1'b0;
                if (rd) begin
                    nxt_state = COMP_RD;
                end else if (wr) begin
                    nxt_state = COMP_WR;
                end
            end
            COMP_RD, COMP_WR: begin
                comp        = 1'b1;
                write       = (state == COMP_WR);
                way_capture = 1'b1;
                data_out    = line_data;
                done        = hit;
                cache_hit   = hit;
                if (hit) begin
                    nxt_state = IDLE;
                end else if (evict_dirty) begin
                    nxt_state = WB_0;
                end else begin
                    nxt_state = FILL_0;
                end
            end
            WB_0, WB_1, WB_2, WB_3: begin
                offset    = {wb_word, 1'b0};
                mem_addr  = {line_tag, addr[10:3], wb_word, 1'b0};   // Victim line address.
                mem_write = 1'b1;
                case (state)
                    WB_0: nxt_state = WB_1;
                    WB_1: nxt_state = WB_2;
                    WB_2: nxt_state = WB_3;
                    default: nxt_state = FILL_0;
                endcase
            end
            FILL_0: nxt_state = FILL_1;
            FILL_1: nxt_state = FILL_2;
            FILL_2: nxt_state = FILL_3;
            FILL_3: nxt_state = FILL_4;
            FILL_4: nxt_state = FILL_5;
            FILL_5: begin
                fill_done = 1'b1;
                done      = 1'b1;
                data_out  = (req_word == 2'd3) ? mem_rdata : read_q;
                nxt_state = IDLE;
            end
            default: nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            req_wr <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state == IDLE) begin
                req_wr <= !rd && wr;   // A read wins if both strobes are high.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr && fill_word == req_word) begin
            read_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* design/main_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module main_mem (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cache_pkg::addr_t mem_addr,
    input  wire cache_pkg::word_t mem_wdata,
    input  wire                   mem_write,
    input  wire                   mem_read,
    output cache_pkg::word_t      mem_rdata
);
    import cache_pkg::*;

    word_t                  mem [MEM_WORDS];
    word_t                  pipe_data [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] pipe_valid;
    logic [14:0]            word_addr;

    assign word_addr = mem_addr[15:1];

    // Every word starts as its own word address scrambled by a fixed key.
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i) ^ MEM_INIT_KEY;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[word_addr] <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], mem_read};
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read) begin
            pipe_data[0] <= mem[word_addr];
        end
        for (int s = 1; s < MEM_LATENCY; s++) begin
            if (pipe_valid[s-1]) begin
                pipe_data[s] <= pipe_data[s-1];
            end
        end
    end

    assign mem_rdata = pipe_valid[MEM_LATENCY-1] ? pipe_data[MEM_LATENCY-1] : '0;

endmodule

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cache_pkg::addr_t addr,
    input  wire cache_pkg::word_t data_in,
    input  wire                   rd,
    input  wire                   wr,
    output cache_pkg::word_t      data_out,
    output logic                  done,
    output logic                  stall,
    output logic                  cache_hit
);
    import cache_pkg::*;

    index_t  index;
    offset_t offset;
    tag_t    tag;
    tag_t    tag_0;
    tag_t    tag_1;
    tag_t    line_tag;
    word_t   cache_wdata;
    word_t   data_0;
    word_t   data_1;
    word_t   line_data;
    word_t   mem_rdata;
    addr_t   mem_addr;
    logic    comp;
    logic    write;
    logic    valid_in;
    logic    dirty_in;
    logic    enable_0;
    logic    enable_1;
    logic    hit_0;
    logic    hit_1;
    logic    valid_0;
    logic    valid_1;
    logic    dirty_0;
    logic    dirty_1;
    logic    hit;
    logic    evict_dirty;
    logic    way_capture;
    logic    fill_done;
    logic    mem_write;
    logic    mem_read;

    cache_ctrl cache_ctrl_inst (
        .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
        .hit(hit), .evict_dirty(evict_dirty), .line_tag(line_tag), .line_data(line_data),
        .mem_rdata(mem_rdata), .index(index), .offset(offset), .tag(tag), .comp(comp),
        .write(write), .cache_wdata(cache_wdata), .valid_in(valid_in), .dirty_in(dirty_in),
        .way_capture(way_capture), .fill_done(fill_done), .mem_addr(mem_addr),
        .mem_write(mem_write), .mem_read(mem_read), .data_out(data_out), .done(done),
        .stall(stall), .cache_hit(cache_hit)
    );

    cache_way way_0_inst (
        .clk(clk), .rst_n(rst_n), .enable(enable_0), .index(index), .offset(offset),
        .tag(tag), .comp(comp), .write(write), .cache_wdata(cache_wdata),
        .valid_in(valid_in), .dirty_in(dirty_in), .hit(hit_0), .valid(valid_0),
        .dirty(dirty_0), .tag_out(tag_0), .data_out(data_0)
    );

    cache_way way_1_inst (
        .clk(clk), .rst_n(rst_n), .enable(enable_1), .index(index), .offset(offset),
        .tag(tag), .comp(comp), .write(write), .cache_wdata(cache_wdata),
        .valid_in(valid_in), .dirty_in(dirty_in), .hit(hit_1), .valid(valid_1),
        .dirty(dirty_1), .tag_out(tag_1), .data_out(data_1)
    );

    way_select way_select_inst (
        .clk(clk), .rst_n(rst_n), .hit_0(hit_0), .hit_1(hit_1), .valid_0(valid_0),
        .valid_1(valid_1), .dirty_0(dirty_0), .dirty_1(dirty_1), .tag_0(tag_0),
        .tag_1(tag_1), .data_0(data_0), .data_1(data_1), .way_capture(way_capture),
        .fill_done(fill_done), .enable_0(enable_0), .enable_1(enable_1), .hit(hit),
        .evict_dirty(evict_dirty), .line_tag(line_tag), .line_data(line_data)
    );

    // Write-back data comes straight from the selected way.
    main_mem main_mem_inst (
        .clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_wdata(line_data),
        .mem_write(mem_write), .mem_read(mem_read), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

/* bench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_REQUESTS = 315;
    localparam int MAX_WAIT     = 20;
    localparam int WATCHDOG_NS  = NUM_REQUESTS * 14 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic   clk;
    logic   rst_n;
    addr_t  addr;
    word_t  data_in;
    logic   rd;
    logic   wr;
    word_t  data_out;
    logic   done;
    logic   stall;
    logic   cache_hit;

    word_t  ref_mem [32768];
    tag_t   ref_tag [2][SETS];
    logic   ref_valid [2][SETS];
    logic   ref_dirty [2][SETS];
    word_t  ref_data [2][SETS][WORDS_PER_LINE];
    logic   ref_victim;

    int     errors;
    int     checks;
    int     tests_run;
    int     test_errors;
    int     last_lat;
    string  test_name;
    integer seed;
    tag_t   evict_tag;
    logic [31:0] r;

    cache_top cache_top_inst (
        .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
        .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) !(done && $past(done)))
        else begin
            $display("done stayed high for more than one cycle");
            errors++;
        end

    hit_with_done: assert property (@(posedge clk) disable iff (!rst_n) cache_hit |-> done)
        else begin
            $display("cache_hit was high without done");
            errors++;
        end

    // The cycle after done is always an idle cycle.
    idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n) $past(done) |-> !stall)
        else begin
            $display("stall was high while the controller was idle");
            errors++;
        end

    // An accepted request keeps stall high up to and including its done cycle.
    stall_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                 (((rd || wr) && !stall) || (stall && !done)) |=> stall)
        else begin
            $display("stall was low while a request was in progress");
            errors++;
        end

    task automatic reset_model();
        for (int i = 0; i < 32768; i++) begin
            ref_mem[i] = 16'(i) ^ 16'hA5C3;
        end
        for (int s = 0; s < SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_dirty[0][s] = 1'b0;
            ref_dirty[1][s] = 1'b0;
        end
        ref_victim = 1'b0;
    endtask

    function automatic void predict_access(input logic is_wr, input addr_t a, input word_t wdata,
                                           output word_t exp_data, output logic exp_hit,
                                           output int exp_lat);
        tag_t       tg;
        index_t     idx;
        logic [1:0] w;
        logic       way;
        tg      = a[15:11];
        idx     = a[10:3];
        w       = a[2:1];
        way     = 1'b0;
        exp_hit = 1'b0;
        exp_lat = 1;
        if (ref_valid[0][idx] && ref_tag[0][idx] == tg) begin
            exp_hit = 1'b1;
        end else if (ref_valid[1][idx] && ref_tag[1][idx] == tg) begin
            exp_hit = 1'b1;
            way     = 1'b1;
        end
        if (!exp_hit) begin
            if (!ref_valid[0][idx]) begin
                way = 1'b0;
            end else if (!ref_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = ref_victim;
            end
            exp_lat = 7;
            if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
                exp_lat = 11;   // Four write-back cycles come first.
                for (int k = 0; k < WORDS_PER_LINE; k++) begin
                    ref_mem[{ref_tag[way][idx], idx, 2'(k)}] = ref_data[way][idx][k];
                end
            end
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                ref_data[way][idx][k] = ref_mem[{tg, idx, 2'(k)}];
            end
            ref_tag[way][idx]   = tg;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = 1'b0;
            ref_victim          = !ref_victim;
        end
        if (is_wr) begin
            ref_data[way][idx][w] = wdata;
            ref_dirty[way][idx]   = 1'b1;
        end
        exp_data = ref_data[way][idx][w];
    endfunction

    task automatic check_value(input string what, input int exp_val, input int got_val);
        checks++;
        assert (exp_val == got_val)
            else begin
                $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp_val,
                         got_val);
                errors++;
            end
    endtask

    // Called 1 ns after a rising edge and returns at the same point of a later cycle.
    task automatic do_access(input logic is_wr, input addr_t a, input word_t wdata);
        word_t exp_data;
        logic  exp_hit;
        int    exp_lat;
        int    lat;
        word_t got_data;
        logic  got_hit;
        predict_access(is_wr, a, wdata, exp_data, exp_hit, exp_lat);
        addr    = a;
        data_in = wdata;
        rd      = !is_wr;
        wr      = is_wr;
        lat     = 0;
        @(negedge clk);
        while (!done && lat < MAX_WAIT) begin
            @(negedge clk);
            lat++;
        end
        got_data = data_out;
        got_hit  = cache_hit;
        if (!done) begin
            $display("No done from the DUT within %0d cycles in test %s", MAX_WAIT, test_name);
            errors++;
        end else begin
            check_value("latency", exp_lat, lat);
            check_value("hit", int'(exp_hit), int'(got_hit));
            if (!is_wr) begin
                check_value("data", int'(exp_data), int'(got_data));
            end
        end
        last_lat = lat;
        @(posedge clk);
        #1;
        rd = 1'b0;
        wr = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    initial begin
        seed      = 89313;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        last_lat  = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        addr      = '0;
        data_in   = '0;
        rd        = 1'b0;
        wr        = 1'b0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("cold_read");
        @(negedge clk);
        check_value("stall after reset", 0, int'(stall));
        check_value("done after reset", 0, int'(done));
        @(posedge clk);
        #1;
        do_access(1'b0, 16'h1234, 16'h0000);
        finish_test();

        begin_test("read_hit");
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            do_access(1'b0, 16'h1230 + 16'(2 * w), 16'h0000);
        end
        finish_test();

        begin_test("write");
        do_access(1'b1, 16'h1232, 16'hBEEF);
        do_access(1'b0, 16'h1232, 16'h0000);
        do_access(1'b1, 16'h4566, 16'hC0DE);   // Write miss allocates the line.
        do_access(1'b0, 16'h4566, 16'h0000);
        do_access(1'b0, 16'h4562, 16'h0000);
        finish_test();

        begin_test("evict");
        do_access(1'b1, {5'd3, 8'h5A, 3'b010}, 16'h3333);
        do_access(1'b1, {5'd9, 8'h5A, 3'b100}, 16'h9999);
        evict_tag = ref_tag[ref_victim][8'h5A];
        do_access(1'b1, {5'd17, 8'h5A, 3'b000}, 16'h1717);
        check_value("dirty miss latency", 11, last_lat);
        do_access(1'b0, {evict_tag, 8'h5A, 3'b010}, 16'h0000);
        do_access(1'b0, {evict_tag, 8'h5A, 3'b100}, 16'h0000);
        finish_test();

        begin_test("random");
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            // Four tags over four sets keep both ways busy with evictions.
            do_access(r[6], {r[1:0], 3'b101, r[3:2], 6'h15, r[5:4], 1'b0}, r[31:16]);
        end
        finish_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/cache_pkg.sv
design/cache_way.sv
design/way_select.sv
cache_ctrl/cache_ctrl.sv
design/main_mem.sv
design/cache_top.sv
bench/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cache_tb -f src.f -o cache_sim

sim_out=$(./obj_dir/cache_sim)
echo "$sim_out"

if grep -qx '>>> PASS' <<< "$sim_out"; then
    exit 0
fi
exit 1
